//--- pinmux_core_pkg.sv
// Block codes, bus widths, register word indices, shared types and byte-write helper
package pinmux_core_pkg;

   // --------------------------------------------------
   // Register bus geometry
   // --------------------------------------------------
   localparam int REG_ADDR_W  = 11;
   localparam int REG_DATA_W  = 32;
   localparam int BE_W        = REG_DATA_W / 8;
   localparam int BLK_SEL_W   = 4;
   localparam int WORD_ADDR_W = 5;

   // Block codes in address bits 10 to 7
   localparam logic [BLK_SEL_W-1:0] SEL_GPIO  = 4'd1;
   localparam logic [BLK_SEL_W-1:0] SEL_TIMER = 4'd3;
   localparam logic [BLK_SEL_W-1:0] SEL_SEMA  = 4'd4;

   // --------------------------------------------------
   // GPIO and pads
   // --------------------------------------------------
   localparam int GPIO_W = 16;

   localparam logic [WORD_ADDR_W-1:0] GPIO_DIR      = 5'd0;
   localparam logic [WORD_ADDR_W-1:0] GPIO_OUT      = 5'd1;
   localparam logic [WORD_ADDR_W-1:0] GPIO_IN       = 5'd2;
   localparam logic [WORD_ADDR_W-1:0] GPIO_INT_STAT = 5'd3;
   localparam logic [WORD_ADDR_W-1:0] GPIO_INT_MASK = 5'd4;
   localparam logic [WORD_ADDR_W-1:0] GPIO_FUNC     = 5'd5;

   // UART pins when the multi-function bit is on
   localparam int UART_RX_PAD = 0;
   localparam int UART_TX_PAD = 1;

   // --------------------------------------------------
   // Timer and semaphore
   // --------------------------------------------------
   localparam logic [WORD_ADDR_W-1:0] TMR_CTRL  = 5'd0;
   localparam logic [WORD_ADDR_W-1:0] TMR_LOAD  = 5'd1;
   localparam logic [WORD_ADDR_W-1:0] TMR_VALUE = 5'd2;
   localparam logic [WORD_ADDR_W-1:0] TMR_STAT  = 5'd3;

   localparam int TICK_DIV = 8;
   localparam int TICK_W   = $clog2(TICK_DIV);
   localparam int TMR_W    = 16;

   // Locks sit at words 0 to 14, status word right above them
   localparam int SEMA_N = 15;
   localparam logic [WORD_ADDR_W-1:0] SEMA_STAT = WORD_ADDR_W'(SEMA_N);

   typedef logic [REG_DATA_W-1:0] reg_data_t;
   typedef logic [GPIO_W-1:0]     gpio_vec_t;
   // Bit 0 GPIO, bit 1 timer
   typedef logic [1:0]            irq_vec_t;

   // Merge the low half of a bus word into a 16-bit register by byte enable
   function automatic logic [15:0] be_merge16(input logic [15:0] old_v,
                                              input reg_data_t   wdata,
                                              input logic [BE_W-1:0] be);
      logic [15:0] mask;
      mask = {{8{be[1]}}, {8{be[0]}}};
      return (old_v & ~mask) | (wdata[15:0] & mask);
   endfunction

endpackage

//--- reg_bus_if.sv
// Register bus interface for one block, with decoder and block modports
`timescale 1ns/1ps

interface reg_bus_if;
   import pinmux_core_pkg::*;

   // Request side, driven by the decoder
   logic                   cs;
   logic                   wr;
   logic [WORD_ADDR_W-1:0] addr;
   reg_data_t              wdata;
   logic [BE_W-1:0]        be;

   // Response side, one-cycle ack with data
   reg_data_t              rdata;
   logic                   ack;

   modport decoder (
      output cs, wr, addr, wdata, be,
      input  rdata, ack
   );

   modport block (
      input  cs, wr, addr, wdata, be,
      output rdata, ack
   );

endinterface

//--- reg_blk_decode.sv
// Block select latch, per-block chip select decode, unmapped ack and read response mux
`timescale 1ns/1ps

module reg_blk_decode (
   input  logic                                   mclk,
   input  logic                                   s_reset_ssn,
   input  logic                                   reg_cs_i,
   input  logic                                   reg_wr_i,
   input  logic [pinmux_core_pkg::REG_ADDR_W-1:0] reg_addr_i,
   input  pinmux_core_pkg::reg_data_t             reg_wdata_i,
   input  logic [pinmux_core_pkg::BE_W-1:0]       reg_be_i,
   output pinmux_core_pkg::reg_data_t             reg_rdata_o,
   output logic                                   reg_ack_o,
   reg_bus_if.decoder                             gpio_bus,
   reg_bus_if.decoder                             tmr_bus,
   reg_bus_if.decoder                             sema_bus
);
   import pinmux_core_pkg::*;

   logic [BLK_SEL_W-1:0]   blk_code;
   logic [BLK_SEL_W-1:0]   blk_sel_q;
   logic [WORD_ADDR_W-1:0] word_addr;
   logic                   unmapped;
   logic                   unmap_ack_q;

   // Block code from bits 10 to 7, word index from bits 6 to 2
   assign blk_code  = reg_addr_i[REG_ADDR_W-1 -: BLK_SEL_W];
   assign word_addr = reg_addr_i[WORD_ADDR_W+1:2];
   assign unmapped  = !(blk_code inside {SEL_GPIO, SEL_TIMER, SEL_SEMA});

   // --------------------------------------------------
   // Request fan-out
   // --------------------------------------------------
   assign gpio_bus.cs    = reg_cs_i && (blk_code == SEL_GPIO);
   assign gpio_bus.wr    = reg_wr_i;
   assign gpio_bus.addr  = word_addr;
   assign gpio_bus.wdata = reg_wdata_i;
   assign gpio_bus.be    = reg_be_i;

   assign tmr_bus.cs     = reg_cs_i && (blk_code == SEL_TIMER);
   assign tmr_bus.wr     = reg_wr_i;
   assign tmr_bus.addr   = word_addr;
   assign tmr_bus.wdata  = reg_wdata_i;
   assign tmr_bus.be     = reg_be_i;

   assign sema_bus.cs    = reg_cs_i && (blk_code == SEL_SEMA);
   assign sema_bus.wr    = reg_wr_i;
   assign sema_bus.addr  = word_addr;
   assign sema_bus.wdata = reg_wdata_i;
   assign sema_bus.be    = reg_be_i;

   // Latched code steers the response while the access is open
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         blk_sel_q   <= '0;
         unmap_ack_q <= 1'b0;
      end else begin
         if (reg_cs_i) begin
            blk_sel_q <= blk_code;
         end
         // Same latency as a block, single pulse on held cs
         unmap_ack_q <= reg_cs_i && unmapped && !unmap_ack_q;
      end
   end

   // --------------------------------------------------
   // Response mux
   // --------------------------------------------------
   always_comb begin
      case (blk_sel_q)
         SEL_GPIO: begin
            reg_rdata_o = gpio_bus.rdata;
            reg_ack_o   = gpio_bus.ack;
         end
         SEL_TIMER: begin
            reg_rdata_o = tmr_bus.rdata;
            reg_ack_o   = tmr_bus.ack;
         end
         SEL_SEMA: begin
            reg_rdata_o = sema_bus.rdata;
            reg_ack_o   = sema_bus.ack;
         end
         default: begin
            // Unmapped space reads as zero
            reg_rdata_o = '0;
            reg_ack_o   = unmap_ack_q;
         end
      endcase
   end

endmodule

//--- gpio_reg.sv
// GPIO direction, output, input, edge interrupt and function select registers
`timescale 1ns/1ps

module gpio_reg (
   input  logic                       mclk,
   input  logic                       s_reset_ssn,
   reg_bus_if.block                   bus,
   input  pinmux_core_pkg::gpio_vec_t pad_gpio_in_i,
   output pinmux_core_pkg::gpio_vec_t gpio_out_o,
   output pinmux_core_pkg::gpio_vec_t gpio_dir_o,
   output logic                       uart_func_en_o,
   output logic                       gpio_intr_o
);
   import pinmux_core_pkg::*;

   gpio_vec_t int_stat_q;
   gpio_vec_t int_mask_q;
   gpio_vec_t in_prev_q;
   gpio_vec_t rise;
   gpio_vec_t stat_clr;
   logic      wr_en;
   logic      rd_en;

   // One access per cs, ack low gates the side effect
   assign wr_en = bus.cs && bus.wr && !bus.ack;
   assign rd_en = bus.cs && !bus.wr && !bus.ack;

   // Rising edges of the synchronised input
   assign rise = pad_gpio_in_i & ~in_prev_q;

   // Write-one-to-clear, only on enabled bytes
   assign stat_clr = (wr_en && bus.addr == GPIO_INT_STAT) ?
                     be_merge16('0, bus.wdata, bus.be) : '0;

   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         bus.ack        <= 1'b0;
         gpio_dir_o     <= '0;
         gpio_out_o     <= '0;
         int_mask_q     <= '0;
         uart_func_en_o <= 1'b0;
         int_stat_q     <= '0;
         in_prev_q      <= '0;
      end else begin
         bus.ack   <= bus.cs && !bus.ack;
         in_prev_q <= pad_gpio_in_i;
         // Edge set wins over a clear in the same cycle
         int_stat_q <= (int_stat_q & ~stat_clr) | rise;
         if (wr_en) begin
            case (bus.addr)
               GPIO_DIR:      gpio_dir_o <= be_merge16(gpio_dir_o, bus.wdata, bus.be);
               GPIO_OUT:      gpio_out_o <= be_merge16(gpio_out_o, bus.wdata, bus.be);
               GPIO_INT_MASK: int_mask_q <= be_merge16(int_mask_q, bus.wdata, bus.be);
               GPIO_FUNC: begin
                  if (bus.be[0]) begin
                     uart_func_en_o <= bus.wdata[0];
                  end
               end
               default: ;
            endcase
         end
      end
   end

   // --------------------------------------------------
   // Read data, captured with the ack
   // --------------------------------------------------
   always_ff @(posedge mclk) begin
      if (rd_en) begin
         case (bus.addr)
            GPIO_DIR:      bus.rdata <= reg_data_t'(gpio_dir_o);
            GPIO_OUT:      bus.rdata <= reg_data_t'(gpio_out_o);
            GPIO_IN:       bus.rdata <= reg_data_t'(pad_gpio_in_i);
            GPIO_INT_STAT: bus.rdata <= reg_data_t'(int_stat_q);
            GPIO_INT_MASK: bus.rdata <= reg_data_t'(int_mask_q);
            GPIO_FUNC:     bus.rdata <= reg_data_t'(uart_func_en_o);
            default:       bus.rdata <= '0;
         endcase
      end
   end

   // Level interrupt from any unmasked status bit
   assign gpio_intr_o = |(int_stat_q & int_mask_q);

endmodule

//--- timer_reg.sv
// Tick prescaler, one-shot down-counter and timer control registers
`timescale 1ns/1ps

module timer_reg (
   input  logic     mclk,
   input  logic     s_reset_ssn,
   reg_bus_if.block bus,
   output logic     timer_intr_o
);
   import pinmux_core_pkg::*;

   logic [TICK_W-1:0] presc_q;
   logic              tick;
   logic              tmr_en_q;
   logic [TMR_W-1:0]  load_q;
   logic [TMR_W-1:0]  count_q;
   logic              hit;
   logic              wr_en;
   logic              rd_en;

   assign wr_en = bus.cs && bus.wr && !bus.ack;
   assign rd_en = bus.cs && !bus.wr && !bus.ack;

   // --------------------------------------------------
   // Prescaler
   // --------------------------------------------------
   assign tick = (presc_q == TICK_W'(TICK_DIV - 1));

   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         presc_q <= '0;
      end else if (tick) begin
         presc_q <= '0;
      end else begin
         presc_q <= presc_q + 1'b1;
      end
   end

   // Last tick before zero
   assign hit = tmr_en_q && tick && (count_q == TMR_W'(1));

   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         bus.ack      <= 1'b0;
         tmr_en_q     <= 1'b0;
         load_q       <= '0;
         count_q      <= '0;
         timer_intr_o <= 1'b0;
      end else begin
         bus.ack <= bus.cs && !bus.ack;
         if (tmr_en_q && tick && count_q != '0) begin
            count_q <= count_q - 1'b1;
         end
         // One-shot, stops itself at zero
         if (hit) begin
            tmr_en_q <= 1'b0;
         end
         if (wr_en) begin
            case (bus.addr)
               TMR_CTRL: begin
                  if (bus.be[0]) begin
                     tmr_en_q <= bus.wdata[0];
                  end
               end
               TMR_LOAD: begin
                  // Counter restarts from the new load value
                  load_q  <= be_merge16(load_q, bus.wdata, bus.be);
                  count_q <= be_merge16(load_q, bus.wdata, bus.be);
               end
               TMR_STAT: begin
                  if (bus.be[0] && bus.wdata[0]) begin
                     timer_intr_o <= 1'b0;
                  end
               end
               default: ;
            endcase
         end
         // Status set beats a clear
         if (hit) begin
            timer_intr_o <= 1'b1;
         end
      end
   end

   always_ff @(posedge mclk) begin
      if (rd_en) begin
         case (bus.addr)
            TMR_CTRL:  bus.rdata <= reg_data_t'(tmr_en_q);
            TMR_LOAD:  bus.rdata <= reg_data_t'(load_q);
            TMR_VALUE: bus.rdata <= reg_data_t'(count_q);
            TMR_STAT:  bus.rdata <= reg_data_t'(timer_intr_o);
            default:   bus.rdata <= '0;
         endcase
      end
   end

endmodule

//--- semaphore_reg.sv
// Fifteen hardware locks, taken by read and released by write, with status word
`timescale 1ns/1ps

module semaphore_reg (
   input  logic     mclk,
   input  logic     s_reset_ssn,
   reg_bus_if.block bus
);
   import pinmux_core_pkg::*;

   logic [SEMA_N-1:0]         lock_q;
   logic [$clog2(SEMA_N)-1:0] lock_idx;
   logic                      lock_hit;
   logic                      access;

   assign access   = bus.cs && !bus.ack;
   assign lock_idx = bus.addr[$clog2(SEMA_N)-1:0];
   // Words 0 to 14 are locks
   assign lock_hit = (bus.addr < SEMA_STAT);

   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         bus.ack <= 1'b0;
         lock_q  <= '0;
      end else begin
         bus.ack <= bus.cs && !bus.ack;
         if (access && lock_hit) begin
            // Read takes the lock, write frees it, data ignored
            lock_q[lock_idx] <= !bus.wr;
         end
      end
   end

   // --------------------------------------------------
   // Read returns 1 only to the taker
   // --------------------------------------------------
   always_ff @(posedge mclk) begin
      if (access) begin
         if (!bus.wr && lock_hit) begin
            bus.rdata <= reg_data_t'(!lock_q[lock_idx]);
         end else if (!bus.wr && bus.addr == SEMA_STAT) begin
            bus.rdata <= reg_data_t'(lock_q);
         end else begin
            bus.rdata <= '0;
         end
      end
   end

endmodule

//--- pad_mux.sv
// Pad input synchroniser and GPIO or UART selection of pad output and enable
`timescale 1ns/1ps

module pad_mux (
   input  logic                       mclk,
   input  logic                       s_reset_ssn,
   input  pinmux_core_pkg::gpio_vec_t digital_io_in_i,
   output pinmux_core_pkg::gpio_vec_t digital_io_out_o,
   output pinmux_core_pkg::gpio_vec_t digital_io_oen_o,
   input  pinmux_core_pkg::gpio_vec_t gpio_out_i,
   input  pinmux_core_pkg::gpio_vec_t gpio_dir_i,
   input  logic                       uart_func_en_i,
   input  logic                       uart_txd_i,
   output pinmux_core_pkg::gpio_vec_t pad_gpio_in_o,
   output logic                       uart_rxd_o
);
   import pinmux_core_pkg::*;

   gpio_vec_t sync_q1;

   // Two-flop synchroniser on every pad
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         sync_q1       <= '0;
         pad_gpio_in_o <= '0;
      end else begin
         sync_q1       <= digital_io_in_i;
         pad_gpio_in_o <= sync_q1;
      end
   end

   // --------------------------------------------------
   // Output and enable, enable is active low
   // --------------------------------------------------
   always_comb begin
      digital_io_out_o = gpio_out_i;
      digital_io_oen_o = ~gpio_dir_i;
      if (uart_func_en_i) begin
         digital_io_out_o[UART_TX_PAD] = uart_txd_i;
         digital_io_oen_o[UART_TX_PAD] = 1'b0;
         // RX pad never drives
         digital_io_out_o[UART_RX_PAD] = 1'b0;
         digital_io_oen_o[UART_RX_PAD] = 1'b1;
      end
   end

   // Line idles high while the function is off
   assign uart_rxd_o = uart_func_en_i ? pad_gpio_in_o[UART_RX_PAD] : 1'b1;

endmodule

//--- pinmux_core_top.sv
// Top level with register decoder, GPIO, timer, semaphore and pad multiplexer
`timescale 1ns/1ps

module pinmux_core_top (
   input  logic                                   mclk,
   input  logic                                   s_reset_ssn,
   // Register bus
   input  logic                                   reg_cs_i,
   input  logic                                   reg_wr_i,
   input  logic [pinmux_core_pkg::REG_ADDR_W-1:0] reg_addr_i,
   input  pinmux_core_pkg::reg_data_t             reg_wdata_i,
   input  logic [pinmux_core_pkg::BE_W-1:0]       reg_be_i,
   output pinmux_core_pkg::reg_data_t             reg_rdata_o,
   output logic                                   reg_ack_o,
   // Interrupts
   output pinmux_core_pkg::irq_vec_t              irq_lines_o,
   // Pads and UART
   input  pinmux_core_pkg::gpio_vec_t             digital_io_in_i,
   output pinmux_core_pkg::gpio_vec_t             digital_io_out_o,
   output pinmux_core_pkg::gpio_vec_t             digital_io_oen_o,
   input  logic                                   uart_txd_i,
   output logic                                   uart_rxd_o
);
   import pinmux_core_pkg::*;

   gpio_vec_t gpio_out;
   gpio_vec_t gpio_dir;
   gpio_vec_t pad_gpio_in;
   logic      uart_func_en;

   reg_bus_if gpio_bus ();
   reg_bus_if tmr_bus ();
   reg_bus_if sema_bus ();

   // --------------------------------------------------
   // Register space
   // --------------------------------------------------
   reg_blk_decode reg_blk_decode_inst (
      .mclk        (mclk),
      .s_reset_ssn (s_reset_ssn),
      .reg_cs_i    (reg_cs_i),
      .reg_wr_i    (reg_wr_i),
      .reg_addr_i  (reg_addr_i),
      .reg_wdata_i (reg_wdata_i),
      .reg_be_i    (reg_be_i),
      .reg_rdata_o (reg_rdata_o),
      .reg_ack_o   (reg_ack_o),
      .gpio_bus    (gpio_bus.decoder),
      .tmr_bus     (tmr_bus.decoder),
      .sema_bus    (sema_bus.decoder)
   );

   gpio_reg gpio_reg_inst (
      .mclk           (mclk),
      .s_reset_ssn    (s_reset_ssn),
      .bus            (gpio_bus.block),
      .pad_gpio_in_i  (pad_gpio_in),
      .gpio_out_o     (gpio_out),
      .gpio_dir_o     (gpio_dir),
      .uart_func_en_o (uart_func_en),
      .gpio_intr_o    (irq_lines_o[0])
   );

   timer_reg timer_reg_inst (
      .mclk         (mclk),
      .s_reset_ssn  (s_reset_ssn),
      .bus          (tmr_bus.block),
      .timer_intr_o (irq_lines_o[1])
   );

   semaphore_reg semaphore_reg_inst (
      .mclk        (mclk),
      .s_reset_ssn (s_reset_ssn),
      .bus         (sema_bus.block)
   );

   // Pads
   pad_mux pad_mux_inst (
      .mclk             (mclk),
      .s_reset_ssn      (s_reset_ssn),
      .digital_io_in_i  (digital_io_in_i),
      .digital_io_out_o (digital_io_out_o),
      .digital_io_oen_o (digital_io_oen_o),
      .gpio_out_i       (gpio_out),
      .gpio_dir_i       (gpio_dir),
      .uart_func_en_i   (uart_func_en),
      .uart_txd_i       (uart_txd_i),
      .pad_gpio_in_o    (pad_gpio_in),
      .uart_rxd_o       (uart_rxd_o)
   );

endmodule

//--- tb_pinmux_core.sv
// Testbench for pinmux_core_top with clock, bus access tasks, directed tests and watchdog
`timescale 1ns/1ps

module tb_pinmux_core;
   import pinmux_core_pkg::*;

   // Whole run is a few hundred cycles, so this leaves a wide margin
   localparam int WATCHDOG_NS = 20000;
   localparam int ACK_LIMIT   = 16;

   logic                  mclk;
   logic                  s_reset_ssn;
   logic                  reg_cs_i;
   logic                  reg_wr_i;
   logic [REG_ADDR_W-1:0] reg_addr_i;
   reg_data_t             reg_wdata_i;
   logic [BE_W-1:0]       reg_be_i;
   reg_data_t             reg_rdata_o;
   logic                  reg_ack_o;
   irq_vec_t              irq_lines_o;
   gpio_vec_t             digital_io_in_i;
   gpio_vec_t             digital_io_out_o;
   gpio_vec_t             digital_io_oen_o;
   logic                  uart_txd_i;
   logic                  uart_rxd_o;
   logic [31:0]           lcg_state;

   pinmux_core_top pinmux_core_top_inst (.*);

   always #5 mclk = ~mclk;

   // --------------------------------------------------
   // Helpers
   // --------------------------------------------------
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic logic [REG_ADDR_W-1:0] make_addr(input logic [BLK_SEL_W-1:0] blk,
                                                       input logic [WORD_ADDR_W-1:0] word);
      return {blk, word, 2'b00};
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         $display("ERROR: %s expected %h actual %h", name, exp, act);
         $display("TEST FAIL");
         $fatal(1, "Value check failed");
      end
   endtask

   // Every wait ends 1 ns after a rising edge
   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge mclk);
         #1;
      end
   endtask

   // One bus access, checks the one-cycle ack latency
   task automatic bus_access(input logic wr, input logic [REG_ADDR_W-1:0] addr,
                             input reg_data_t wdata, input logic [BE_W-1:0] be,
                             output reg_data_t rdata);
      int cycles;
      cycles      = 0;
      reg_cs_i    = 1'b1;
      reg_wr_i    = wr;
      reg_addr_i  = addr;
      reg_wdata_i = wdata;
      reg_be_i    = be;
      do begin
         wait_cycles(1);
         cycles++;
      end while (!reg_ack_o && cycles < ACK_LIMIT);
      assert (reg_ack_o) else begin
         $display("Register bus gave no ack for address %h", addr);
         $display("TEST FAIL");
         $fatal(1, "Missing ack");
      end
      check_value("ack latency", 1, cycles);
      rdata    = reg_rdata_o;
      reg_cs_i = 1'b0;
      reg_wr_i = 1'b0;
      // Idle cycle, ack must drop
      wait_cycles(1);
      check_value("ack pulse width", 0, reg_ack_o);
   endtask

   task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input reg_data_t wdata,
                            input logic [BE_W-1:0] be);
      reg_data_t unused;
      bus_access(1'b1, addr, wdata, be, unused);
   endtask

   task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, output reg_data_t rdata);
      bus_access(1'b0, addr, '0, '1, rdata);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before the tests finished");
      $display("TEST FAIL");
      $fatal(1, "Watchdog timeout");
   end

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial begin
      reg_data_t rd;
      gpio_vec_t pat_dir;
      gpio_vec_t pat_out;
      gpio_vec_t pat_in;
      int        cnt;
      mclk            = 1'b0;
      s_reset_ssn     = 1'b0;
      reg_cs_i        = 1'b0;
      reg_wr_i        = 1'b0;
      reg_addr_i      = '0;
      reg_wdata_i     = '0;
      reg_be_i        = '0;
      digital_io_in_i = '0;
      uart_txd_i      = 1'b1;
      lcg_state       = 32'd99;
      repeat (5) @(posedge mclk);
      #1;
      s_reset_ssn = 1'b1;
      wait_cycles(1);

      // Reset state
      check_value("reset oen", 16'hffff, digital_io_oen_o);
      check_value("reset out", 0, digital_io_out_o);
      check_value("reset irq", 0, irq_lines_o);
      check_value("reset ack", 0, reg_ack_o);

      // Unmapped blocks and byte enables
      read_reg(make_addr(4'd0, 5'd0), rd);
      check_value("unmapped block 0", 0, rd);
      read_reg(make_addr(4'd9, 5'd3), rd);
      check_value("unmapped block 9", 0, rd);
      // Upper byte preset so a lost byte shows up
      write_reg(make_addr(SEL_GPIO, GPIO_OUT), 32'h0000ff00, 4'hf);
      write_reg(make_addr(SEL_GPIO, GPIO_OUT), 32'h0000abcd, 4'h1);
      read_reg(make_addr(SEL_GPIO, GPIO_OUT), rd);
      check_value("gpio out byte enable", 32'h0000ffcd, rd);
      check_value("pad out byte enable", 16'hffcd, digital_io_out_o);

      // Random direction and output onto the pads
      pat_dir = lcg_next() >> 16;
      pat_out = lcg_next() >> 16;
      write_reg(make_addr(SEL_GPIO, GPIO_DIR), 32'(pat_dir), 4'hf);
      write_reg(make_addr(SEL_GPIO, GPIO_OUT), 32'(pat_out), 4'hf);
      check_value("pad out", pat_out, digital_io_out_o);
      check_value("pad oen", gpio_vec_t'(~pat_dir), digital_io_oen_o);

      // Pad inputs read back after the synchroniser
      pat_in          = lcg_next() >> 16;
      digital_io_in_i = pat_in;
      wait_cycles(3);
      read_reg(make_addr(SEL_GPIO, GPIO_IN), rd);
      check_value("gpio in", 32'(pat_in), rd);

      // Edge interrupt on pad 5, start from a clean status
      digital_io_in_i = '0;
      wait_cycles(3);
      write_reg(make_addr(SEL_GPIO, GPIO_INT_STAT), 32'hffff, 4'hf);
      write_reg(make_addr(SEL_GPIO, GPIO_INT_MASK), 32'h0020, 4'hf);
      digital_io_in_i[5] = 1'b1;
      wait_cycles(4);
      check_value("gpio irq raised", 1, irq_lines_o[0]);
      write_reg(make_addr(SEL_GPIO, GPIO_INT_STAT), 32'h0020, 4'hf);
      check_value("gpio irq cleared", 0, irq_lines_o[0]);
      write_reg(make_addr(SEL_GPIO, GPIO_INT_MASK), 32'h0, 4'hf);
      digital_io_in_i[5] = 1'b0;
      wait_cycles(3);
      digital_io_in_i[5] = 1'b1;
      wait_cycles(4);
      check_value("gpio irq masked", 0, irq_lines_o[0]);

      // UART function on pads 0 and 1
      write_reg(make_addr(SEL_GPIO, GPIO_DIR), 32'h0001, 4'hf);
      write_reg(make_addr(SEL_GPIO, GPIO_FUNC), 32'h1, 4'hf);
      check_value("rx pad oen", 1, digital_io_oen_o[UART_RX_PAD]);
      check_value("tx pad oen", 0, digital_io_oen_o[UART_TX_PAD]);
      uart_txd_i = 1'b0;
      wait_cycles(1);
      check_value("tx pad low", 0, digital_io_out_o[UART_TX_PAD]);
      uart_txd_i = 1'b1;
      wait_cycles(1);
      check_value("tx pad high", 1, digital_io_out_o[UART_TX_PAD]);
      digital_io_in_i[UART_RX_PAD] = 1'b0;
      wait_cycles(3);
      check_value("rxd low", 0, uart_rxd_o);
      digital_io_in_i[UART_RX_PAD] = 1'b1;
      wait_cycles(1);
      check_value("rxd after one edge", 0, uart_rxd_o);
      wait_cycles(1);
      check_value("rxd after two edges", 1, uart_rxd_o);

      // Timer, load 5 and enable
      write_reg(make_addr(SEL_TIMER, TMR_LOAD), 32'd5, 4'hf);
      write_reg(make_addr(SEL_TIMER, TMR_CTRL), 32'h1, 4'hf);
      // Enable took effect one cycle before the task returned
      cnt = 1;
      while (!irq_lines_o[1] && cnt < 6 * TICK_DIV + 2) begin
         wait_cycles(1);
         cnt++;
      end
      check_value("timer irq in time", 1, irq_lines_o[1]);
      check_value("timer irq not early", 1, cnt >= 4 * TICK_DIV);
      read_reg(make_addr(SEL_TIMER, TMR_VALUE), rd);
      check_value("timer value", 0, rd);
      write_reg(make_addr(SEL_TIMER, TMR_STAT), 32'h1, 4'hf);
      check_value("timer irq cleared", 0, irq_lines_o[1]);

      // Semaphore lock 3
      read_reg(make_addr(SEL_SEMA, 5'd3), rd);
      check_value("lock 3 take", 1, rd);
      read_reg(make_addr(SEL_SEMA, 5'd3), rd);
      check_value("lock 3 busy", 0, rd);
      read_reg(make_addr(SEL_SEMA, SEMA_STAT), rd);
      check_value("lock status held", 32'h8, rd);
      write_reg(make_addr(SEL_SEMA, 5'd3), 32'h0, 4'hf);
      read_reg(make_addr(SEL_SEMA, SEMA_STAT), rd);
      check_value("lock status free", 0, rd);
      read_reg(make_addr(SEL_SEMA, 5'd3), rd);
      check_value("lock 3 retake", 1, rd);

      $display("TEST PASS");
      $finish;
   end

endmodule

//--- pinmux_core.f
pinmux_core_pkg.sv
reg_bus_if.sv
reg_blk_decode.sv
gpio_reg.sv
timer_reg.sv
semaphore_reg.sv
pad_mux.sv
pinmux_core_top.sv
tb_pinmux_core.sv
